// File: source/noc_defs.svh
`ifndef NOC_DEFS_SVH
`define NOC_DEFS_SVH

// ==============================
// Mesh and link sizing
// ==============================

`define NOC_NODE_COUNT 9
`define NOC_NODE_W 4
`define NOC_PKT_ID_W 5

// Packet queue entries in the splitter, and flits held by the link buffer
`define NOC_QUEUE_DEPTH 8
`define NOC_LINK_DEPTH 4

`endif

// File: source/noc_pkg.sv
`include "noc_defs.svh"

package noc_pkg;

    // Upper two bits hold the column code, lower two bits the row code
    typedef logic [3:0] mesh_xy_t;

    // ==============================
    // Packet and flit formats
    // ==============================

    typedef struct packed {
        logic [71:0]               payload;
        logic [`NOC_NODE_W-1:0]    dest_node;
        logic [`NOC_PKT_ID_W-1:0]  packet_id;
    } packet_t;

    typedef struct packed {
        mesh_xy_t                  dest_xy;
        logic [7:0]                data;
        logic [`NOC_PKT_ID_W-1:0]  packet_id;
        logic [`NOC_NODE_W-1:0]    src_node;
        logic [3:0]                seq;
    } flit_t;

    typedef struct packed {
        logic [71:0]               payload;
        mesh_xy_t                  dest_xy;
        logic [`NOC_PKT_ID_W-1:0]  packet_id;
        logic [`NOC_NODE_W-1:0]    src_node;
    } out_packet_t;

endpackage

// File: source/sync_queue.sv
module sync_queue #(
    parameter int  DEPTH   = 4,
    parameter type entry_t = logic [7:0]
) (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   push,
    input  entry_t push_data,
    input  logic   pop,
    output entry_t pop_data,
    output logic   not_empty,
    output logic   not_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign not_empty = (count != '0);
    assign not_full  = (count != (PTR_W + 1)'(DEPTH));

    // A push into a full queue or a pop from an empty one has no effect
    assign do_push = push && not_full;
    assign do_pop  = pop && not_empty;

    assign pop_data = mem[head];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                tail <= (tail == LAST_PTR) ? '0 : tail + 1'b1;
            end
            if (do_pop) begin
                head <= (head == LAST_PTR) ? '0 : head + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[tail] <= push_data;
        end
    end

endmodule

// File: source/packet_splitter.sv
`include "noc_defs.svh"

module packet_splitter #(
    parameter int NODE_ID = 0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             in_valid,
    input  noc_pkg::packet_t in_pkt,
    output logic             in_ready,
    output logic             flit_valid,
    output noc_pkg::flit_t   flit,
    input  logic             credit_return
);

    import noc_pkg::*;

    localparam int MESH_DIM = 3;
    localparam int CREDIT_W = $clog2(`NOC_LINK_DEPTH + 1);
    localparam logic [3:0] LAST_SEQ = 4'd8;

    packet_t             head_pkt;
    logic                head_valid;
    logic                send;
    logic                last_flit;
    logic [3:0]          byte_cnt;
    logic [CREDIT_W-1:0] credit_cnt;

    // Node n sits at column n mod 3 and row n div 3, anything past the mesh is 1111
    function automatic mesh_xy_t mesh_encode(input logic [`NOC_NODE_W-1:0] node);
        int unsigned col;
        int unsigned row;
        col = node % MESH_DIM;
        row = node / MESH_DIM;
        if (node >= `NOC_NODE_COUNT) begin
            return 4'b1111;
        end
        return {col[1:0], row[1:0]};
    endfunction

    // ==============================
    // Packet queue
    // ==============================

    sync_queue #(
        .DEPTH   (`NOC_QUEUE_DEPTH),
        .entry_t (packet_t)
    ) u_pkt_queue (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (in_valid),
        .push_data (in_pkt),
        .pop       (last_flit),
        .pop_data  (head_pkt),
        .not_empty (head_valid),
        .not_full  (in_ready)
    );

    // ==============================
    // Flit generation and credits
    // ==============================

    // A flit may only leave while the link buffer has a free slot reserved for it
    assign send      = head_valid && (credit_cnt != '0);
    assign last_flit = send && (byte_cnt == LAST_SEQ);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flit_valid <= 1'b0;
            byte_cnt   <= '0;
            credit_cnt <= CREDIT_W'(`NOC_LINK_DEPTH);
        end else begin
            flit_valid <= send;
            if (send) begin
                byte_cnt <= last_flit ? '0 : byte_cnt + 4'd1;
            end
            // Sending and a returned credit in the same cycle cancel out
            case ({send, credit_return})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;
                2'b01:   credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Byte 0 is the most significant byte of the payload
    always_ff @(posedge clk) begin
        if (send) begin
            flit.dest_xy   <= mesh_encode(head_pkt.dest_node);
            flit.data      <= head_pkt.payload[(LAST_SEQ - byte_cnt) * 8 +: 8];
            flit.packet_id <= head_pkt.packet_id;
            flit.src_node  <= NODE_ID[`NOC_NODE_W-1:0];
            flit.seq       <= byte_cnt;
        end
    end

endmodule

// File: source/flit_assembler.sv
module flit_assembler (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 link_valid,
    input  noc_pkg::flit_t       link_flit,
    output logic                 link_pop,
    output logic                 out_valid,
    output noc_pkg::out_packet_t out_pkt,
    input  logic                 out_ready
);

    localparam logic [3:0] LAST_SEQ = 4'd8;

    logic take;
    logic last_flit;

    // ==============================
    // Link side
    // ==============================

    assign take = out_valid && out_ready;

    // A finished packet blocks the link until the consumer takes it
    assign link_pop  = link_valid && (!out_valid || out_ready);
    assign last_flit = link_pop && (link_flit.seq == LAST_SEQ);

    // ==============================
    // Output register
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (last_flit) begin
            out_valid <= 1'b1;
        end else if (take) begin
            out_valid <= 1'b0;
        end
    end

    // The packet is built in place, since a pop never happens while a finished
    // packet is still waiting
    always_ff @(posedge clk) begin
        if (link_pop) begin
            out_pkt.payload[(LAST_SEQ - link_flit.seq) * 8 +: 8] <= link_flit.data;
            out_pkt.dest_xy   <= link_flit.dest_xy;
            out_pkt.packet_id <= link_flit.packet_id;
            out_pkt.src_node  <= link_flit.src_node;
        end
    end

endmodule

// File: source/noc_link.sv
`include "noc_defs.svh"

module noc_link #(
    parameter int NODE_ID = 0
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  noc_pkg::packet_t     in_pkt,
    output logic                 in_ready,
    output logic                 out_valid,
    output noc_pkg::out_packet_t out_pkt,
    input  logic                 out_ready
);

    import noc_pkg::*;

    logic  flit_valid;
    flit_t flit;
    logic  link_valid;
    flit_t link_flit;
    logic  link_pop;

    packet_splitter #(
        .NODE_ID (NODE_ID)
    ) u_splitter (
        .clk           (clk),
        .rst_n         (rst_n),
        .in_valid      (in_valid),
        .in_pkt        (in_pkt),
        .in_ready      (in_ready),
        .flit_valid    (flit_valid),
        .flit          (flit),
        .credit_return (link_pop)
    );

    // Credits guarantee room, so the full flag of the link buffer is not needed
    sync_queue #(
        .DEPTH   (`NOC_LINK_DEPTH),
        .entry_t (flit_t)
    ) u_link_buf (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (flit_valid),
        .push_data (flit),
        .pop       (link_pop),
        .pop_data  (link_flit),
        .not_empty (link_valid),
        .not_full  ()
    );

    flit_assembler u_assembler (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_valid (link_valid),
        .link_flit  (link_flit),
        .link_pop   (link_pop),
        .out_valid  (out_valid),
        .out_pkt    (out_pkt),
        .out_ready  (out_ready)
    );

endmodule

// File: sim/noc_link_chk.sv
`include "noc_defs.svh"

module noc_link_chk (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic                                   flit_valid,
    input noc_pkg::flit_t                         flit,
    input logic [$clog2(`NOC_LINK_DEPTH + 1)-1:0] credit_cnt,
    input logic                                   link_not_full
);
    timeunit 1ns;
    timeprecision 100ps;

    int         assert_failures = 0;
    logic       seen_flit;
    logic [3:0] prev_seq;
    logic [3:0] expected_seq;

    // ==============================
    // Flit sequence tracking
    // ==============================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seen_flit <= 1'b0;
            prev_seq  <= '0;
        end else if (flit_valid) begin
            seen_flit <= 1'b1;
            prev_seq  <= flit.seq;
        end
    end

    // The first flit after reset starts a packet, later ones count up to 8 and wrap
    assign expected_seq = !seen_flit ? 4'd0 : ((prev_seq == 4'd8) ? 4'd0 : prev_seq + 4'd1);

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= `NOC_LINK_DEPTH)
    else begin
        $error("credit count %0d above the link buffer depth", credit_cnt);
        assert_failures++;
    end

    // Zero credit means no free slot, so a flit on the link must always find room
    flit_has_slot: assert property (@(posedge clk) disable iff (!rst_n)
        flit_valid |-> link_not_full)
    else begin
        $error("flit pushed into a full link buffer");
        assert_failures++;
    end

    seq_order: assert property (@(posedge clk) disable iff (!rst_n)
        flit_valid |-> flit.seq == expected_seq)
    else begin
        $error("flit seq %0d where %0d was due", flit.seq, expected_seq);
        assert_failures++;
    end

endmodule

bind noc_link noc_link_chk u_chk (
    .clk           (clk),
    .rst_n         (rst_n),
    .flit_valid    (flit_valid),
    .flit          (flit),
    .credit_cnt    (u_splitter.credit_cnt),
    .link_not_full (u_link_buf.not_full)
);

// File: sim/noc_link_tb.sv
`include "noc_defs.svh"

module noc_link_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import noc_pkg::*;

    localparam int NODE_ID         = 5;
    localparam int MAX_PACKETS     = 1 + 16 + 12 + `NOC_QUEUE_DEPTH + 1 + 40;
    localparam int WATCHDOG_CYCLES = MAX_PACKETS * 9 * 4 + 16;

    logic        clk;
    logic        rst_n;
    logic        in_valid;
    packet_t     in_pkt;
    logic        in_ready;
    logic        out_valid;
    out_packet_t out_pkt;
    logic        out_ready;
    out_packet_t exp_q[$];
    out_packet_t exp_pkt;
    logic [31:0] rng_state = 32'd96;
    string       test_name;
    int          total_errors;
    int          test_errors;
    int          test_checks;
    int          tests_run;

    noc_link #(
        .NODE_ID (NODE_ID)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_pkt    (in_pkt),
        .in_ready  (in_ready),
        .out_valid (out_valid),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // ==============================
    // Reference model
    // ==============================

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Column code n mod 3 in the upper bits, row code n div 3 in the lower bits
    function automatic mesh_xy_t mesh_xy_of(input int node);
        int row;
        int col;
        row = 0;
        col = node;
        if (node >= `NOC_NODE_COUNT) begin
            return 4'b1111;
        end
        while (col >= 3) begin
            col -= 3;
            row++;
        end
        return {col[1:0], row[1:0]};
    endfunction

    function automatic out_packet_t expected_of(input packet_t p);
        out_packet_t e;
        e.payload   = p.payload;
        e.dest_xy   = mesh_xy_of(p.dest_node);
        e.packet_id = p.packet_id;
        e.src_node  = 4'(NODE_ID);
        return e;
    endfunction

    function automatic packet_t random_packet();
        packet_t     p;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        a = next_rand();
        b = next_rand();
        c = next_rand();
        p.payload   = {a, b, c[7:0]};
        p.packet_id = c[12:8];
        p.dest_node = c[19:16];
        return p;
    endfunction

    // Every packet taken at the output must be the oldest one still expected
    always @(posedge clk) begin
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("test %s: a packet was delivered that was never sent", test_name);
                test_errors++;
            end else begin
                exp_pkt = exp_q.pop_front();
                test_checks++;
                assert (out_pkt == exp_pkt) else begin
                    $display("CHECK FAILED %s: expected %h actual %h",
                             test_name, exp_pkt, out_pkt);
                    test_errors++;
                end
            end
        end
    end

    // ==============================
    // Driver tasks
    // ==============================

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
        test_checks = 0;
    endtask

    task automatic finish_test();
        $display("test %-14s %0d checks, %0d errors", test_name, test_checks, test_errors);
        total_errors += test_errors;
        tests_run++;
    endtask

    // Called just after a falling edge, returns one falling edge after the transfer
    task automatic offer_packet(input packet_t p);
        in_pkt   = p;
        in_valid = 1'b1;
        while (!in_ready) @(negedge clk);
        exp_q.push_back(expected_of(p));
        @(negedge clk);
    endtask

    task automatic wait_delivered(input int max_cycles);
        int waited;
        waited = 0;
        while (exp_q.size() != 0 && waited < max_cycles) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("test %s: %0d packets were never delivered", test_name, exp_q.size());
            test_errors++;
            exp_q.delete();
        end
    endtask

    // ==============================
    // Tests
    // ==============================

    task automatic round_trip_single();
        start_test("single_packet");
        offer_packet(random_packet());
        in_valid = 1'b0;
        wait_delivered(100);
        finish_test();
    endtask

    task automatic sweep_destinations();
        packet_t p;
        start_test("dest_coding");
        for (int n = 0; n < 16; n++) begin
            p = random_packet();
            p.dest_node = n[3:0];
            offer_packet(p);
            in_valid = 1'b0;
            wait_delivered(100);
        end
        finish_test();
    endtask

    task automatic burst_back_to_back();
        start_test("burst");
        for (int i = 0; i < 12; i++) begin
            offer_packet(random_packet());
        end
        in_valid = 1'b0;
        wait_delivered(12 * 9 * 3);
        finish_test();
    endtask

    task automatic fill_under_back_pressure();
        packet_t p;
        int      accepted;
        int      low_run;
        start_test("back_pressure");
        out_ready = 1'b0;
        accepted  = 0;
        low_run   = 0;
        p = random_packet();
        // Keep offering until in_ready has stayed low long enough for the stall to settle
        while (low_run < 20 && accepted < 30) begin
            in_pkt   = p;
            in_valid = 1'b1;
            if (in_ready) begin
                exp_q.push_back(expected_of(p));
                accepted++;
                low_run = 0;
                p = random_packet();
            end else begin
                low_run++;
            end
            @(negedge clk);
        end
        in_valid = 1'b0;
        test_checks++;
        // A packet keeps its queue slot until its last flit leaves, so beyond the
        // queue only the packet held in the assembler can be in flight
        assert (accepted <= `NOC_QUEUE_DEPTH + 1) else begin
            $display("CHECK FAILED %s: accepted expected at most %0d actual %0d",
                     test_name, `NOC_QUEUE_DEPTH + 1, accepted);
            test_errors++;
        end
        out_ready = 1'b1;
        wait_delivered(accepted * 9 * 3);
        test_checks++;
        assert (in_ready) else begin
            $display("CHECK FAILED %s: in_ready expected 1 actual %b", test_name, in_ready);
            test_errors++;
        end
        finish_test();
    endtask

    task automatic random_traffic();
        logic [31:0] r;
        int          sent;
        int          cycles;
        logic        taken;
        start_test("random_traffic");
        sent   = 0;
        cycles = 0;
        taken  = 1'b0;
        while ((sent < 40 || exp_q.size() != 0) && cycles < 40 * 9 * 4) begin
            r = next_rand();
            out_ready = r[0] | r[1];
            if (taken) begin
                in_valid = 1'b0;
                taken    = 1'b0;
            end
            if (!in_valid && sent < 40 && r[2]) begin
                in_pkt   = random_packet();
                in_valid = 1'b1;
            end
            if (in_valid && in_ready) begin
                exp_q.push_back(expected_of(in_pkt));
                sent++;
                taken = 1'b1;
            end
            @(negedge clk);
            cycles++;
        end
        in_valid  = 1'b0;
        out_ready = 1'b1;
        if (sent < 40 || exp_q.size() != 0) begin
            $display("test %s: traffic stalled with %0d of 40 sent and %0d outstanding",
                     test_name, sent, exp_q.size());
            test_errors++;
            exp_q.delete();
        end
        finish_test();
    endtask

    initial begin
        in_valid     = 1'b0;
        in_pkt       = '0;
        out_ready    = 1'b1;
        rst_n        = 1'b0;
        total_errors = 0;
        tests_run    = 0;
        test_name    = "reset";
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        assert (in_ready && !out_valid) else begin
            $display("CHECK FAILED %s: in_ready expected 1 actual %b, out_valid expected 0 actual %b",
                     test_name, in_ready, out_valid);
            total_errors++;
        end
        round_trip_single();
        sweep_destinations();
        burst_back_to_back();
        fill_under_back_pressure();
        random_traffic();
        total_errors += UUT.u_chk.assert_failures;
        $display("%0d tests run, %0d errors, %0d assertion failures",
                 tests_run, total_errors, UUT.u_chk.assert_failures);
        if (total_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+source
source/noc_pkg.sv
source/sync_queue.sv
source/packet_splitter.sv
source/flit_assembler.sv
source/noc_link.sv
sim/noc_link_chk.sv
sim/noc_link_tb.sv
